//--- rtl/iso14443a_consts.svh
// fixed timing and width constants for the ISO 14443 Type A receive path
// included by the packages and by any module that compares against the windows
`ifndef ISO14443A_CONSTS_SVH
`define ISO14443A_CONSTS_SVH

// --------------------------------------------------
// air interface bit timing, in carrier clock ticks
// --------------------------------------------------
// one bit time at 106 kbit/s
`define ISO_BIT_TICKS   (128)
// an X pause sits half a bit time into the bit
`define ISO_HALF_BIT    (`ISO_BIT_TICKS / 2)

// --------------------------------------------------
// widened decode windows, measured between pause ends
// --------------------------------------------------
// shortest legal gap after a Y
`define SEQ_WIN_MIN     (8)
// timeout after X or Y, Z/X boundary after Z
`define SEQ_WIN_SHORT   (`ISO_BIT_TICKS + 4)
// timeout after Z
`define SEQ_WIN_LONG    (`ISO_BIT_TICKS + `ISO_HALF_BIT + 4)
// three quiet bit times after a timing error
`define SEQ_WIN_ERR     (3 * `ISO_BIT_TICKS)

// widths
`define RX_COUNTER_W    9
`define RX_SYNC_STAGES  2
`define RX_BYTE_W       8
`define RX_BITCNT_W     4

`endif

//--- rtl/iso14443a_pkg.sv
// types for the reader-to-card air interface: Miller sequences and the bit stream
// used by the sequence decoder and everything that consumes its output
`include "iso14443a_consts.svh"

package iso14443a_pkg;

    // --------------------------------------------------
    // modified Miller sequences
    // --------------------------------------------------
    // X: pause half way into the bit time
    // Y: no pause for the whole bit time
    // Z: pause at the start of the bit time
    // ERROR: pause outside every legal window
    typedef enum logic [1:0] {
        X     = 2'd0,
        Y     = 2'd1,
        Z     = 2'd2,
        ERROR = 2'd3
    } pcd_seq_e;

    // ticks counted since the last pause end
    typedef logic [`RX_COUNTER_W-1:0] gap_cnt_t;

    // --------------------------------------------------
    // decoded bit stream
    // --------------------------------------------------
    // every flag is a one cycle strobe, at most one high per cycle
    // data only means something while data_valid is high
    typedef struct packed {
        logic soc;
        logic eoc;
        logic error;
        logic data_valid;
        logic data;
    } rx_bit_s;

endpackage

//--- rtl/rx_frame_pkg.sv
// types for the decoded frame output of the receive path
// shared by the byte assembler and the blocks that take its bytes
`include "iso14443a_consts.svh"

package rx_frame_pkg;

    // one received byte value
    typedef logic [`RX_BYTE_W-1:0] rx_data_t;

    // number of valid bits in a byte, 1 to 8
    typedef logic [`RX_BITCNT_W-1:0] rx_bitcnt_t;

    // --------------------------------------------------
    // received byte as seen by the protocol layer
    // --------------------------------------------------
    // partial bytes come right aligned, lsb first on air
    typedef struct packed {
        rx_data_t   data;
        rx_bitcnt_t bit_count;
        logic       parity_error;
    } rx_byte_s;

    // byte assembler FSM
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        DATA    = 2'd1,
        PARITY  = 2'd2,
        DISCARD = 2'd3
    } asm_state_e;

endpackage

//--- rtl/sequence_decode.sv
// turns the pause signal of the analogue front end into Miller sequences
// and then into a strobed bit stream with SOC, EOC and error markers
`include "iso14443a_consts.svh"

module sequence_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    // asynchronous, low while the field is paused
    input  logic                  pause_n,
    output iso14443a_pkg::rx_bit_s bit_stream
);

    // window limits as counter sized values
    localparam iso14443a_pkg::gap_cnt_t WIN_MIN   = iso14443a_pkg::gap_cnt_t'(`SEQ_WIN_MIN);
    localparam iso14443a_pkg::gap_cnt_t WIN_HALF  = iso14443a_pkg::gap_cnt_t'(`ISO_HALF_BIT);
    localparam iso14443a_pkg::gap_cnt_t WIN_SHORT = iso14443a_pkg::gap_cnt_t'(`SEQ_WIN_SHORT);
    localparam iso14443a_pkg::gap_cnt_t WIN_LONG  = iso14443a_pkg::gap_cnt_t'(`SEQ_WIN_LONG);
    localparam iso14443a_pkg::gap_cnt_t WIN_ERR   = iso14443a_pkg::gap_cnt_t'(`SEQ_WIN_ERR);

    // --------------------------------------------------
    // synchroniser and end of pause detection
    // --------------------------------------------------
    logic [`RX_SYNC_STAGES-1:0] sync_q;
    logic                       pause_sync;
    logic                       last_pause_n;
    logic                       pause_end;

    // resets to all ones, i.e. not in a pause
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q       <= '1;
            last_pause_n <= 1'b1;
        end else begin
            sync_q       <= {sync_q[`RX_SYNC_STAGES-2:0], pause_n};
            last_pause_n <= pause_sync;
        end
    end

    assign pause_sync = sync_q[`RX_SYNC_STAGES-1];
    // rising edge of the synchronised pause signal
    assign pause_end  = !last_pause_n && pause_sync;

    // --------------------------------------------------
    // sequence classifier
    // --------------------------------------------------
    iso14443a_pkg::gap_cnt_t gap_cnt;
    iso14443a_pkg::pcd_seq_e seq;
    iso14443a_pkg::pcd_seq_e seq_on_pause;
    logic                    seq_valid;
    logic                    seq_soc;
    logic                    idle;
    logic                    timed_out;

    // what a pause ending right now would mean, given the last sequence
    always_comb begin
        case (seq)
            iso14443a_pkg::X: begin
                // a pause earlier than half a bit would be Z after X, not legal
                if (gap_cnt < WIN_HALF) begin
                    seq_on_pause = iso14443a_pkg::ERROR;
                end else begin
                    seq_on_pause = iso14443a_pkg::X;
                end
            end
            iso14443a_pkg::Z: begin
                if (gap_cnt < WIN_HALF) begin
                    seq_on_pause = iso14443a_pkg::ERROR;
                end else if (gap_cnt < WIN_SHORT) begin
                    seq_on_pause = iso14443a_pkg::Z;
                end else begin
                    seq_on_pause = iso14443a_pkg::X;
                end
            end
            iso14443a_pkg::Y: begin
                // after Y the counter started at the timeout, so gaps run short
                if (gap_cnt < WIN_MIN) begin
                    seq_on_pause = iso14443a_pkg::ERROR;
                end else if (gap_cnt < WIN_HALF) begin
                    seq_on_pause = iso14443a_pkg::Z;
                end else begin
                    seq_on_pause = iso14443a_pkg::X;
                end
            end
            // once in error, stay there until the quiet time runs out
            default: seq_on_pause = iso14443a_pkg::ERROR;
        endcase
    end

    // no pause inside the window, so this bit time was a Y
    always_comb begin
        case (seq)
            iso14443a_pkg::X:     timed_out = (gap_cnt == WIN_SHORT);
            iso14443a_pkg::Y:     timed_out = (gap_cnt == WIN_SHORT);
            iso14443a_pkg::Z:     timed_out = (gap_cnt == WIN_LONG);
            default:              timed_out = (gap_cnt == WIN_ERR);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle      <= 1'b1;
            seq       <= iso14443a_pkg::Y;
            seq_valid <= 1'b0;
            seq_soc   <= 1'b0;
            gap_cnt   <= '0;
        end else begin
            seq_valid <= 1'b0;
            seq_soc   <= 1'b0;
            if (idle) begin
                // first pause from idle is the Z of SOC
                if (pause_end) begin
                    idle      <= 1'b0;
                    seq       <= iso14443a_pkg::Z;
                    seq_valid <= 1'b1;
                    seq_soc   <= 1'b1;
                    gap_cnt   <= iso14443a_pkg::gap_cnt_t'(1);
                end
            end else if (pause_end) begin
                gap_cnt <= iso14443a_pkg::gap_cnt_t'(1);
                seq     <= seq_on_pause;
                // pauses while in error are swallowed
                seq_valid <= (seq != iso14443a_pkg::ERROR);
            end else if (timed_out) begin
                gap_cnt   <= iso14443a_pkg::gap_cnt_t'(1);
                seq       <= iso14443a_pkg::Y;
                seq_valid <= 1'b1;
                // second Y in a row, the reader has stopped talking
                if (seq == iso14443a_pkg::Y) begin
                    idle <= 1'b1;
                end
            end else begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // sequences to bits, SOC, EOC and error
    // --------------------------------------------------
    // each bit is only known once the next sequence arrives
    iso14443a_pkg::pcd_seq_e prev_seq;
    logic                    prev_soc;
    logic                    in_frame;
    logic                    prev_is_zero;

    // Y and Z both carry a logic 0
    assign prev_is_zero = (prev_seq == iso14443a_pkg::Y) || (prev_seq == iso14443a_pkg::Z);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_seq   <= iso14443a_pkg::Y;
            prev_soc   <= 1'b0;
            in_frame   <= 1'b0;
            bit_stream <= '0;
        end else begin
            bit_stream <= '0;
            if (seq_valid) begin
                prev_seq <= seq;
                prev_soc <= seq_soc;
                if (seq_soc) begin
                    // nothing to say until the following sequence
                end else if (prev_soc) begin
                    bit_stream.soc <= 1'b1;
                    in_frame       <= 1'b1;
                end else if (in_frame) begin
                    if (prev_is_zero && (seq == iso14443a_pkg::Y)) begin
                        // logic 0 then Y closes the frame
                        bit_stream.eoc <= 1'b1;
                        in_frame       <= 1'b0;
                    end else if (prev_seq == iso14443a_pkg::ERROR) begin
                        bit_stream.error <= 1'b1;
                    end else begin
                        bit_stream.data_valid <= 1'b1;
                        bit_stream.data       <= (prev_seq == iso14443a_pkg::X);
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    // eoc needs a data bit between it and soc, so never both at once
    soc_eoc_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(bit_stream.soc && bit_stream.eoc));

    // every window restarts the counter before the error quiet time
    gap_cnt_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        gap_cnt <= WIN_ERR);

endmodule

//--- rtl/rx_byte_assembler.sv
// packs the decoded bit stream into bytes with odd parity check
// and flushes a trailing partial byte, such as a short frame, at EOC
`include "iso14443a_consts.svh"

module rx_byte_assembler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  iso14443a_pkg::rx_bit_s  bit_stream,
    output rx_frame_pkg::rx_byte_s  rx_byte,
    output logic                    byte_valid,
    output logic                    frame_start,
    output logic                    frame_end,
    output logic                    frame_error
);

    localparam rx_frame_pkg::rx_bitcnt_t FULL_BYTE = rx_frame_pkg::rx_bitcnt_t'(`RX_BYTE_W);
    localparam rx_frame_pkg::rx_bitcnt_t LAST_BIT  = rx_frame_pkg::rx_bitcnt_t'(`RX_BYTE_W - 1);

    rx_frame_pkg::asm_state_e state;
    rx_frame_pkg::rx_bitcnt_t bit_cnt;
    rx_frame_pkg::rx_data_t   data_q;
    // running xor of the data bits of the current byte
    logic                     par_acc;

    logic take_bit;
    logic take_par;
    logic flush;

    // --------------------------------------------------
    // actions this cycle
    // --------------------------------------------------
    always_comb begin
        take_bit = (state == rx_frame_pkg::DATA) && bit_stream.data_valid;
        take_par = (state == rx_frame_pkg::PARITY) && bit_stream.data_valid;
        // eoc with some bits held, 8 held means the parity bit never came
        flush    = bit_stream.eoc &&
                   (((state == rx_frame_pkg::DATA) && (bit_cnt != '0)) ||
                    (state == rx_frame_pkg::PARITY));
    end

    // --------------------------------------------------
    // FSM and strobes
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= rx_frame_pkg::IDLE;
            bit_cnt     <= '0;
            par_acc     <= 1'b0;
            byte_valid  <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= take_par || flush;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            frame_error <= 1'b0;
            if (bit_stream.soc) begin
                // a new frame always starts clean
                state       <= rx_frame_pkg::DATA;
                bit_cnt     <= '0;
                par_acc     <= 1'b0;
                frame_start <= 1'b1;
            end else begin
                case (state)
                    rx_frame_pkg::DATA, rx_frame_pkg::PARITY: begin
                        if (take_bit) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            par_acc <= par_acc ^ bit_stream.data;
                            if (bit_cnt == LAST_BIT) begin
                                state <= rx_frame_pkg::PARITY;
                            end
                        end else if (take_par) begin
                            bit_cnt <= '0;
                            par_acc <= 1'b0;
                            state   <= rx_frame_pkg::DATA;
                        end else if (bit_stream.eoc) begin
                            frame_end <= 1'b1;
                            state     <= rx_frame_pkg::IDLE;
                        end else if (bit_stream.error) begin
                            // partial byte is lost, wait for the frame to close
                            frame_error <= 1'b1;
                            state       <= rx_frame_pkg::DISCARD;
                        end
                    end
                    rx_frame_pkg::DISCARD: begin
                        if (bit_stream.eoc) begin
                            frame_end <= 1'b1;
                            state     <= rx_frame_pkg::IDLE;
                        end
                    end
                    default: begin
                        // idle, anything but soc is ignored
                    end
                endcase
            end
        end
    end

    // --------------------------------------------------
    // byte payload
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        // lsb arrives first, so each bit lands at its final position
        if (bit_stream.soc || take_par) begin
            data_q <= '0;
        end else if (take_bit) begin
            data_q[bit_cnt[2:0]] <= bit_stream.data;
        end
        if (take_par) begin
            rx_byte.data         <= data_q;
            rx_byte.bit_count    <= FULL_BYTE;
            // odd parity, so an even count of ones is an error
            rx_byte.parity_error <= ~(par_acc ^ bit_stream.data);
        end else if (flush) begin
            rx_byte.data         <= data_q;
            rx_byte.bit_count    <= bit_cnt;
            rx_byte.parity_error <= 1'b0;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    byte_from_data_state: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |-> ($past(state) == rx_frame_pkg::DATA ||
                        $past(state) == rx_frame_pkg::PARITY));

    bit_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        bit_cnt <= FULL_BYTE);

endmodule

//--- rtl/iso14443a_rx.sv
// receive path of an ISO 14443 Type A card, reader to card direction
// takes the front end pause signal and delivers framed bytes

module iso14443a_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    // asynchronous pause indication, low during a pause
    input  logic                   pause_n,
    output rx_frame_pkg::rx_byte_s rx_byte,
    output logic                   byte_valid,
    output logic                   frame_start,
    output logic                   frame_end,
    output logic                   frame_error
);

    // --------------------------------------------------
    // decoder to assembler
    // --------------------------------------------------
    iso14443a_pkg::rx_bit_s bit_stream;

    // Miller decoding, bits come out one bit time late
    sequence_decode sequence_decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pause_n    (pause_n),
        .bit_stream (bit_stream)
    );

    // bytes, parity and frame markers
    rx_byte_assembler rx_byte_assembler_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .bit_stream  (bit_stream),
        .rx_byte     (rx_byte),
        .byte_valid  (byte_valid),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .frame_error (frame_error)
    );

endmodule

//--- tests/iso14443a_rx_tb.sv
// testbench for the Type A receive path, Miller codes the frames of the stimulus file
// into pause_n and checks strobes and bytes of the DUT against the expected lines
`include "iso14443a_consts.svh"

module iso14443a_rx_tb;

    // --------------------------------------------------
    // run constants
    // --------------------------------------------------
    // pause_n low time before every pause end, in clocks
    localparam int PAUSE_LOW      = 4;
    localparam int TIMEOUT_CYCLES = 4000;
    // quiet time after a frame, decoder is idle well before this
    localparam int IDLE_CYCLES    = 512;
    // characters seen by the bit string reader
    localparam int CHAR_0   = 48;
    localparam int CHAR_1   = 49;
    localparam int CHAR_NL  = 10;
    localparam int CHAR_EOF = -1;

    typedef enum logic [1:0] {
        EV_START = 2'd0,
        EV_BYTE  = 2'd1,
        EV_ERROR = 2'd2,
        EV_END   = 2'd3
    } ev_kind_e;

    // one strobe seen by the monitor, with the byte of that cycle
    typedef struct packed {
        ev_kind_e               kind;
        rx_frame_pkg::rx_byte_s rx_byte;
    } ev_s;

    // one E line of the stimulus file
    typedef struct packed {
        rx_frame_pkg::rx_data_t   data;
        rx_frame_pkg::rx_bitcnt_t bit_count;
        logic                     parity_error;
        logic                     frame_error;
    } exp_s;

    logic                   clk;
    logic                   rst_n;
    logic                   pause_n;
    rx_frame_pkg::rx_byte_s rx_byte;
    logic                   byte_valid;
    logic                   frame_start;
    logic                   frame_end;
    logic                   frame_error;

    ev_s  ev_q[$];
    exp_s exp_q[$];
    bit   frame_bits[$];
    // clocks from one pause end to the next
    int   gap_q[$];
    int   frame_gap;
    int   frame_count;
    int   fd;

    iso14443a_rx dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pause_n     (pause_n),
        .rx_byte     (rx_byte),
        .byte_valid  (byte_valid),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .frame_error (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // monitor
    // --------------------------------------------------
    function automatic ev_s make_event(input ev_kind_e kind);
        ev_s ev;
        ev.kind    = kind;
        ev.rx_byte = rx_byte;
        return ev;
    endfunction

    // outputs settle after posedge, so look at them on negedge
    // a flushed byte is queued ahead of the frame_end of its cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (frame_start) begin
                ev_q.push_back(make_event(EV_START));
            end
            if (byte_valid) begin
                ev_q.push_back(make_event(EV_BYTE));
            end
            if (frame_error) begin
                ev_q.push_back(make_event(EV_ERROR));
            end
            if (frame_end) begin
                ev_q.push_back(make_event(EV_END));
            end
        end
    end

    // --------------------------------------------------
    // reporting and waiting
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] observed,
                               input logic [31:0] expected);
        if (observed !== expected) begin
            abort_run($sformatf("FAIL time=%0t signal=%s observed=%0h expected=%0h",
                                $time, name, observed, expected));
        end
    endtask

    // every drive lands 1 time unit after the rising edge
    task automatic tick_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic next_event(input string what, output ev_s ev);
        int waited;
        waited = 0;
        while (ev_q.size() == 0 && waited < TIMEOUT_CYCLES) begin
            tick_cycles(1);
            waited++;
        end
        if (ev_q.size() == 0) begin
            abort_run($sformatf("timeout: %s never came within %0d cycles",
                                what, TIMEOUT_CYCLES));
        end else begin
            ev = ev_q.pop_front();
        end
    endtask

    // --------------------------------------------------
    // Miller coding and pause generation
    // --------------------------------------------------
    task automatic pause_after(input int gap);
        tick_cycles(gap - PAUSE_LOW);
        pause_n = 1'b0;
        tick_cycles(PAUSE_LOW);
        // the rising edge is the pause end that the decoder times
        pause_n = 1'b1;
    endtask

    // pause end positions in ticks, SOC pause end at 0
    task automatic build_gaps();
        int k;
        int n_air;
        int pos;
        int last_pos;
        bit prev_one;
        bit value;
        gap_q.delete();
        // SOC is a Z in bit time 0
        gap_q.push_back(PAUSE_LOW);
        last_pos = 0;
        prev_one = 1'b0;
        // data bits and the closing logic 0, unless a bad gap replaces the end
        n_air = (frame_gap > 0) ? frame_bits.size() : frame_bits.size() + 1;
        for (k = 0; k < n_air; k++) begin
            value = (k < frame_bits.size()) ? frame_bits[k] : 1'b0;
            if (value) begin
                // X, half a bit into bit time k+1
                pos = (k + 1) * `ISO_BIT_TICKS + `ISO_HALF_BIT;
                gap_q.push_back(pos - last_pos);
                last_pos = pos;
            end else if (!prev_one) begin
                // Z after a 0 or after SOC
                pos = (k + 1) * `ISO_BIT_TICKS;
                gap_q.push_back(pos - last_pos);
                last_pos = pos;
            end
            // 0 after a 1 is Y, no pause at all
            prev_one = value;
        end
        // closing Y has no pause, the decoder times it out
        if (frame_gap > 0) begin
            gap_q.push_back(frame_gap);
        end
    endtask

    // --------------------------------------------------
    // one frame, sent and then checked from the queue
    // --------------------------------------------------
    task automatic run_frame();
        ev_s  ev;
        exp_s ex;
        int   i;
        int   g;
        // nothing may come out between frames or before the first one
        check_value("strobes while idle", 32'(ev_q.size()), 32'd0);
        build_gaps();
        for (g = 0; g < gap_q.size(); g++) begin
            pause_after(gap_q[g]);
        end
        next_event("frame_start", ev);
        check_value("frame_start", 32'(ev.kind), 32'(EV_START));
        for (i = 0; i < exp_q.size(); i++) begin
            ex = exp_q[i];
            if (ex.frame_error) begin
                next_event("frame_error", ev);
                check_value("frame_error", 32'(ev.kind), 32'(EV_ERROR));
            end else begin
                next_event("byte_valid", ev);
                check_value("byte_valid", 32'(ev.kind), 32'(EV_BYTE));
                check_value("rx_byte.data", 32'(ev.rx_byte.data), 32'(ex.data));
                check_value("rx_byte.bit_count", 32'(ev.rx_byte.bit_count),
                            32'(ex.bit_count));
                check_value("rx_byte.parity_error", 32'(ev.rx_byte.parity_error),
                            32'(ex.parity_error));
            end
        end
        next_event("frame_end", ev);
        check_value("frame_end", 32'(ev.kind), 32'(EV_END));
        tick_cycles(IDLE_CYCLES);
        frame_count++;
    endtask

    // --------------------------------------------------
    // stimulus file reader
    // --------------------------------------------------
    task automatic read_bits();
        int c;
        frame_bits.delete();
        c = $fgetc(fd);
        // spaces between groups are skipped
        while (c != CHAR_NL && c != CHAR_EOF) begin
            if (c == CHAR_0 || c == CHAR_1) begin
                frame_bits.push_back(c == CHAR_1);
            end
            c = $fgetc(fd);
        end
    endtask

    task automatic skip_line();
        int c;
        c = $fgetc(fd);
        while (c != CHAR_NL && c != CHAR_EOF) begin
            c = $fgetc(fd);
        end
    endtask

    initial begin
        logic [7:0] kind;
        int         code;
        int         e_data;
        int         e_count;
        int         e_perr;
        int         e_err;
        exp_s       ex;
        bit         have_frame;
        bit         done;
        rst_n       = 1'b0;
        pause_n     = 1'b1;
        frame_gap   = 0;
        frame_count = 0;
        have_frame  = 1'b0;
        done        = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick_cycles(64);

        fd = $fopen("tests/rx_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/rx_stimulus.txt from the working directory");
        end else begin
            // a frame runs once its T, G and E lines are all read
            while (!done) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    skip_line();
                end else if (kind == "T") begin
                    if (have_frame) begin
                        run_frame();
                    end
                    read_bits();
                    exp_q.delete();
                    frame_gap  = 0;
                    have_frame = 1'b1;
                end else if (kind == "G") begin
                    code = $fscanf(fd, "%d", frame_gap);
                    if (code != 1 || !have_frame || frame_gap < PAUSE_LOW) begin
                        abort_run("G line outside a frame or with an unusable gap");
                    end
                end else if (kind == "E") begin
                    code = $fscanf(fd, "%h %d %d %d", e_data, e_count, e_perr, e_err);
                    if (code != 4 || !have_frame) begin
                        abort_run("E line malformed or outside a frame");
                    end else begin
                        ex.data         = 8'(e_data);
                        ex.bit_count    = 4'(e_count);
                        ex.parity_error = e_perr[0];
                        ex.frame_error  = e_err[0];
                        exp_q.push_back(ex);
                    end
                end else begin
                    abort_run($sformatf("unknown line kind %c in the stimulus file", kind));
                end
            end
            if (have_frame) begin
                run_frame();
            end
            $fclose(fd);
        end

        check_value("strobes after the last frame", 32'(ev_q.size()), 32'd0);
        if (frame_count == 0) begin
            abort_run("the stimulus file holds no frame");
        end else begin
            $display("frames checked: %0d", frame_count);
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- iso14443a_rx.f
+incdir+rtl
rtl/iso14443a_pkg.sv
rtl/rx_frame_pkg.sv
rtl/sequence_decode.sv
rtl/rx_byte_assembler.sv
rtl/iso14443a_rx.sv
tests/iso14443a_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the receive path testbench with Verilator and runs it
# the run passes only if the simulation log holds the pass line

cd "$(dirname "$0")" || exit 1

top=iso14443a_rx_tb
obj_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert \
    -f iso14443a_rx.f \
    --top-module "$top" \
    -Mdir "$obj_dir" > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $build_log"
    exit 1
fi

"./$obj_dir/V$top" > "$sim_log" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -qx "Done: no errors" "$sim_log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $sim_log"
    exit 1
fi

//--- tests/rx_stimulus.txt
# T: bits in air order, lsb first, byte frames carry a parity bit after each byte
# G: bad gap in ticks sent instead of the frame end   E: data(hex) bit_count parity_error frame_error
# two bytes 93 20 with good parity
T 11001001 1 00000100 0
E 93 8 0 0
E 20 8 0 0
# 50 00 57, parity of the middle byte inverted
T 00001010 1 00000000 0 11101010 0
E 50 8 0 0
E 00 8 1 0
E 57 8 0 0
# REQA short frame, 7 bits and no parity
T 0110010
E 26 7 0 0
# pause end 40 ticks after an X, partial byte must be dropped
T 101
G 40
E 00 0 0 1
# same frame as the first one, after the error and idle
T 11001001 1 00000100 0
E 93 8 0 0
E 20 8 0 0
